/* all.f */
mpf_pkg.sv
mpf_rsp_order.sv
mpf_wr_order.sv
mpf_shim_stack.sv
tb_clock_gen.sv
tb_mem_model.sv
tb_mpf_shim_stack.sv

/* Bender.yml */
package:
  name: mpf_shim_stack

sources:
  - files:
      - mpf_pkg.sv
      - mpf_rsp_order.sv
      - mpf_wr_order.sv
      - mpf_shim_stack.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_mem_model.sv
      - tb_mpf_shim_stack.sv

/* tb_mpf_shim_stack.sv */
// Directed tests of the shim stack; reads only touch lines that an earlier write in the run has set
`timescale 1ns/1ps

module tb_mpf_shim_stack
    import mpf_pkg::*;
();

    localparam int ROB_DEPTH   = 8;
    localparam int WRO_DEPTH   = 4;
    localparam int FIU_CREDITS = 4;
    // Requests issued over the whole run, which sizes the watchdog
    localparam int TOTAL_REQS  = 4 * ROB_DEPTH + 4;

    logic     clk;
    logic     arst_n;
    mpf_req_t afu_req;
    logic     afu_credit;
    mpf_rsp_t afu_rsp;
    mpf_req_t fiu_req;
    logic     fiu_credit;
    mpf_rsp_t fiu_rsp;
    logic     credit_overrun;

    // Client view: expected responses in request order and the last data written per line
    mpf_rsp_t              exp_q [$];
    logic [MPF_DATA_W-1:0] shadow [16];
    string                 cur_test;
    int                    credits;
    int                    credit_pulses;
    int                    issued;
    int                    responses;
    int                    errors;

    tb_clock_gen #(.PERIOD_NS(4.0), .RST_CYCLES(3)) u_clock_gen (.clk(clk), .arst_n(arst_n));

    mpf_shim_stack #(
        .ROB_DEPTH   (ROB_DEPTH),
        .WRO_DEPTH   (WRO_DEPTH),
        .FIU_CREDITS (FIU_CREDITS)
    ) u_mpf_shim_stack (
        .clk        (clk),
        .arst_n     (arst_n),
        .afu_req    (afu_req),
        .afu_credit (afu_credit),
        .afu_rsp    (afu_rsp),
        .fiu_req    (fiu_req),
        .fiu_credit (fiu_credit),
        .fiu_rsp    (fiu_rsp)
    );

    tb_mem_model #(.FIU_CREDITS(FIU_CREDITS)) u_mem_model (
        .clk            (clk),
        .arst_n         (arst_n),
        .fiu_req        (fiu_req),
        .fiu_credit     (fiu_credit),
        .fiu_rsp        (fiu_rsp),
        .credit_overrun (credit_overrun)
    );

    // ==================================================
    // Client monitor
    // ==================================================

    // Falling edge sampling keeps clear of the DUT register updates
    always @(negedge clk)
    begin
        if (afu_credit === 1'b1)
        begin
            credits++;
            credit_pulses++;
        end
        if (afu_rsp.valid === 1'b1)
        begin
            responses++;
            if (exp_q.size() == 0)
            begin
                $display("%s: a response arrived with no request outstanding", cur_test);
                errors++;
            end
            else
            begin
                if (afu_rsp !== exp_q[0])
                begin
                    $display("Fail %s: expected %h, actual %h", cur_test, exp_q[0], afu_rsp);
                    errors++;
                end
                void'(exp_q.pop_front());
            end
        end
    end

    // ==================================================
    // Driver helpers
    // ==================================================

    // One request a short delay after the edge, once a client credit is free
    task automatic send_req(input logic is_write, input logic [MPF_ADDR_W-1:0] addr,
                            input logic [MPF_DATA_W-1:0] data,
                            input logic [MPF_MDATA_W-1:0] mdata);
        mpf_rsp_t want;
        while (credits == 0)
        begin
            @(posedge clk);
            #1;
        end
        afu_req = '{valid: 1'b1, is_write: is_write, addr: addr, data: data, mdata: mdata};
        want = '{valid: 1'b1, is_write: is_write, data: '0, mdata: mdata};
        // A read returns whatever the last earlier write to its line left there
        if (is_write)
        begin
            shadow[addr[3:0]] = data;
        end
        else
        begin
            want.data = shadow[addr[3:0]];
        end
        exp_q.push_back(want);
        credits--;
        issued++;
        @(posedge clk);
        #1;
        afu_req = '0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic report_test(input int start);
        if (errors == start)
        begin
            $display("%s: passed", cur_test);
        end
        else
        begin
            $display("%s: failed with %0d errors", cur_test, errors - start);
        end
    endtask

    // ==================================================
    // Directed tests
    // ==================================================

    task automatic test_reset();
        int start;
        start    = errors;
        cur_test = "reset";
        for (int i = 0; i < 8; i++)
        begin
            @(posedge clk);
            #1;
            if (afu_rsp.valid !== 1'b0 || afu_credit !== 1'b0 || fiu_req.valid !== 1'b0)
            begin
                $display("%s: a valid or credit output was high in cycle %0d", cur_test, i);
                errors++;
            end
        end
        report_test(start);
    endtask

    // Preload lines by writes, then read them back in reverse line order
    task automatic test_read_order();
        int start;
        start    = errors;
        cur_test = "read_order";
        for (int i = 0; i < ROB_DEPTH; i++)
        begin
            send_req(1'b1, MPF_ADDR_W'(i), {16'hda7a, 16'(i), ~32'(i)}, 8'(8'h10 + i));
        end
        wait_drain();
        for (int i = 0; i < ROB_DEPTH; i++)
        begin
            send_req(1'b0, MPF_ADDR_W'(ROB_DEPTH - 1 - i), '0, 8'(8'h80 + i));
        end
        wait_drain();
        report_test(start);
    endtask

    task automatic test_same_line();
        int start;
        start    = errors;
        cur_test = "same_line";
        send_req(1'b1, 16'd9, 64'h1111_2222_3333_4444, 8'h21);
        send_req(1'b0, 16'd9, '0, 8'h22);
        send_req(1'b1, 16'd9, 64'h5555_6666_7777_8888, 8'h23);
        send_req(1'b0, 16'd9, '0, 8'h24);
        wait_drain();
        report_test(start);
    endtask

    // Writes to fresh lines interleaved with reads of old and new lines
    task automatic test_write_rsp();
        int start;
        start    = errors;
        cur_test = "write_rsp";
        for (int i = 0; i < 4; i++)
        begin
            send_req(1'b1, MPF_ADDR_W'(10 + i), {32'h0bad_f00d, 32'(i)}, 8'(8'h40 + 2 * i));
            send_req(1'b0, MPF_ADDR_W'((i < 2) ? i : 8 + i), '0, 8'(8'h41 + 2 * i));
        end
        wait_drain();
        report_test(start);
    endtask

    task automatic test_credits();
        int start;
        int pulses0;
        int rsp0;
        int req0;
        start    = errors;
        cur_test = "credits";
        if (credits != ROB_DEPTH)
        begin
            $display("Fail %s: expected %0d, actual %0d", cur_test, ROB_DEPTH, credits);
            errors++;
        end
        pulses0 = credit_pulses;
        rsp0    = responses;
        req0    = issued;
        for (int i = 0; i < ROB_DEPTH; i++)
        begin
            send_req(1'b0, MPF_ADDR_W'(i), '0, 8'(8'hc0 + i));
        end
        wait_drain();
        repeat (4)
        begin
            @(posedge clk);
            #1;
        end
        if (credit_pulses - pulses0 != ROB_DEPTH)
        begin
            $display("Fail %s: expected %0d, actual %0d", cur_test, ROB_DEPTH,
                     credit_pulses - pulses0);
            errors++;
        end
        if (responses - rsp0 != issued - req0)
        begin
            $display("Fail %s: expected %0d, actual %0d", cur_test, issued - req0,
                     responses - rsp0);
            errors++;
        end
        report_test(start);
    endtask

    // ==================================================
    // Sequence and watchdog
    // ==================================================

    initial
    begin
        afu_req       = '0;
        cur_test      = "";
        credits       = ROB_DEPTH;
        credit_pulses = 0;
        issued        = 0;
        responses     = 0;
        errors        = 0;
        test_reset();
        test_read_order();
        test_same_line();
        test_write_rsp();
        test_credits();
        if (credit_overrun)
        begin
            $display("The memory port received a request beyond its credits");
            errors++;
        end
        $display("Summary: %0d requests, %0d responses, %0d credit pulses, %0d errors",
                 issued, responses, credit_pulses, errors);
        if (errors == 0)
        begin
            $display("Test OK");
        end
        else
        begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial
    begin
        repeat (200 * TOTAL_REQS + 1000) @(posedge clk);
        $display("Watchdog expired with %0d requests and %0d responses", issued, responses);
        $display("Test FAILED");
        $finish;
    end

endmodule

/* tb_mem_model.sv */
// At most one answer per cycle, in random order; lines are indexed by the low four address bits
`timescale 1ns/1ps

module tb_mem_model
    import mpf_pkg::*;
#(
    parameter int FIU_CREDITS = 4
)
(
    input  logic     clk,
    input  logic     arst_n,
    input  mpf_req_t fiu_req,
    output logic     fiu_credit,
    output mpf_rsp_t fiu_rsp,
    output logic     credit_overrun
);

    // Sixteen lines of backing store
    logic [MPF_DATA_W-1:0] lines [16];

    // Requests accepted but not yet answered
    mpf_req_t              pending [$];
    mpf_req_t              pick;
    integer                seed;
    logic [31:0]           roll;
    int                    idx;

    initial
    begin
        seed           = 32'hb6f4_3c92;
        fiu_credit     = 1'b0;
        fiu_rsp        = '0;
        credit_overrun = 1'b0;
        // Each fill word carries its own line index
        for (int i = 0; i < 16; i++)
        begin
            lines[i] = 64'h5eed_0000_0000_0000 + 64'(i);
        end

        // Outputs change a short delay after the edge and inputs are read there too
        forever
        begin
            @(posedge clk);
            #1;
            fiu_rsp    = '0;
            fiu_credit = 1'b0;
            if (!arst_n)
            begin
                pending.delete();
            end
            else
            begin
                if (fiu_req.valid)
                begin
                    pending.push_back(fiu_req);
                end
                if (pending.size() > FIU_CREDITS)
                begin
                    $display("Memory model holds more requests than the credits it handed out");
                    credit_overrun = 1'b1;
                end

                // Skipping some cycles at random lets requests pile up for the pick below
                roll = $random(seed);

                // Any pending request may go next, which scrambles the return order
                if (pending.size() != 0 && roll[0])
                begin
                    idx  = $unsigned($random(seed)) % pending.size();
                    pick = pending[idx];
                    pending.delete(idx);
                    fiu_rsp.valid    = 1'b1;
                    fiu_rsp.is_write = pick.is_write;
                    fiu_rsp.mdata    = pick.mdata;
                    if (pick.is_write)
                    begin
                        lines[pick.addr[3:0]] = pick.data;
                    end
                    else
                    begin
                        fiu_rsp.data = lines[pick.addr[3:0]];
                    end
                    fiu_credit = 1'b1;
                end
            end
        end
    end

endmodule

/* tb_clock_gen.sv */
// Free-running clock from time zero; reset releases half a nanosecond after the last reset edge
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD_NS  = 4.0,
    parameter int  RST_CYCLES = 3
)
(
    output logic clk,
    output logic arst_n
);

    // Clock starts low so the first rising edge comes half a period in
    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(PERIOD_NS / 2.0) clk = ~clk;
        end
    end

    // A clean falling reset edge, then release away from any clock edge
    initial
    begin
        arst_n = 1'b1;
        #1 arst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #(PERIOD_NS / 8.0) arst_n = 1'b1;
    end

endmodule

/* mpf_shim_stack.sv */
// Client must respect its ROB_DEPTH credits and accept every response; memory may answer out of order
`timescale 1ns/1ps

module mpf_shim_stack
    import mpf_pkg::*;
#(
    parameter int ROB_DEPTH   = 8,
    parameter int WRO_DEPTH   = 4,
    parameter int FIU_CREDITS = 4
)
(
    input  logic     clk,
    input  logic     arst_n,
    input  mpf_req_t afu_req,
    output logic     afu_credit,
    output mpf_rsp_t afu_rsp,
    output mpf_req_t fiu_req,
    input  logic     fiu_credit,
    input  mpf_rsp_t fiu_rsp
);

    // Hop between the two shims, with tags already in mdata
    mpf_req_t mid_req;
    logic     mid_credit;
    mpf_rsp_t mid_rsp;

    // ==================================================
    // Response ordering, closest to the client
    // ==================================================

    // Restores client mdata and returns responses in request order
    mpf_rsp_order #(
        .ROB_DEPTH  (ROB_DEPTH),
        .WRO_DEPTH  (WRO_DEPTH)
    ) u_rsp_order (
        .clk        (clk),
        .arst_n     (arst_n),
        .afu_req    (afu_req),
        .afu_credit (afu_credit),
        .afu_rsp    (afu_rsp),
        .fiu_req    (mid_req),
        .fiu_credit (mid_credit),
        .fiu_rsp    (mid_rsp)
    );

    // ==================================================
    // Write ordering, closest to the memory port
    // ==================================================

    // Holds back same-line hazards using the tags assigned above
    mpf_wr_order #(
        .ROB_DEPTH   (ROB_DEPTH),
        .WRO_DEPTH   (WRO_DEPTH),
        .FIU_CREDITS (FIU_CREDITS)
    ) u_wr_order (
        .clk        (clk),
        .arst_n     (arst_n),
        .up_req     (mid_req),
        .up_credit  (mid_credit),
        .up_rsp     (mid_rsp),
        .fiu_req    (fiu_req),
        .fiu_credit (fiu_credit),
        .fiu_rsp    (fiu_rsp)
    );

endmodule

/* mpf_wr_order.sv */
// Tags in mdata must be unique among in-flight requests, as the reorder shim above provides
`timescale 1ns/1ps

module mpf_wr_order
    import mpf_pkg::*;
#(
    parameter int ROB_DEPTH   = 8,
    parameter int WRO_DEPTH   = 4,
    parameter int FIU_CREDITS = 4
)
(
    input  logic     clk,
    input  logic     arst_n,
    input  mpf_req_t up_req,
    output logic     up_credit,
    output mpf_rsp_t up_rsp,
    output mpf_req_t fiu_req,
    input  logic     fiu_credit,
    input  mpf_rsp_t fiu_rsp
);

    localparam int TAG_W = mpf_tag_w(ROB_DEPTH);
    localparam int PTR_W = mpf_tag_w(WRO_DEPTH);
    localparam int CNT_W = $clog2(WRO_DEPTH + 1);
    localparam int CRD_W = $clog2(FIU_CREDITS + 1);

    // What the conflict check needs to know about a request at memory
    typedef struct packed {
        logic                  is_write;
        logic [MPF_ADDR_W-1:0] addr;
    } wro_entry_t;

    // Request FIFO, sized by the credits handed upstream
    mpf_req_t              fifo_mem [WRO_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      fifo_cnt;
    logic                  fifo_empty;

    // In-flight table, one entry per reorder tag
    wro_entry_t            tbl [ROB_DEPTH];
    logic [ROB_DEPTH-1:0]  tbl_valid;

    // Credits held for the memory port
    logic [CRD_W-1:0]      fiu_cnt;

    mpf_req_t              head;
    logic [TAG_W-1:0]      head_tag;
    logic [TAG_W-1:0]      rsp_tag;
    logic                  conflict;
    logic                  issue_go;
    logic                  push;
    logic                  pop;

    assign fifo_empty = (fifo_cnt == '0);
    assign head       = fifo_empty ? up_req : fifo_mem[rd_ptr];
    assign head_tag   = head.mdata[TAG_W-1:0];
    assign rsp_tag    = fiu_rsp.mdata[TAG_W-1:0];

    // ==================================================
    // Same-line conflict check
    // ==================================================

    // A write waits for anything in flight to its line
    // A read only waits for an in-flight write to its line
    always_comb
    begin
        conflict = 1'b0;
        for (int i = 0; i < ROB_DEPTH; i++)
        begin
            if (tbl_valid[i] && (tbl[i].addr == head.addr) &&
                (head.is_write || tbl[i].is_write))
            begin
                conflict = 1'b1;
            end
        end
    end

    // An empty FIFO lets the arriving request issue without being stored
    assign issue_go = head.valid && !conflict && (fiu_cnt != '0);
    assign push     = up_req.valid && !(fifo_empty && issue_go);
    assign pop      = issue_go && !fifo_empty;

    // Payload storage, guarded by fifo_cnt and tbl_valid
    always_ff @(posedge clk)
    begin
        if (push)
        begin
            fifo_mem[wr_ptr] <= up_req;
        end
        if (issue_go)
        begin
            tbl[head_tag] <= '{is_write: head.is_write, addr: head.addr};
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            fifo_cnt  <= '0;
            tbl_valid <= '0;
            fiu_cnt   <= CRD_W'(FIU_CREDITS);
            fiu_req   <= '0;
            up_credit <= 1'b0;
            up_rsp    <= '0;
        end
        else
        begin
            // Pointers wrap at the depth, which need not be a power of two
            if (push)
            begin
                wr_ptr <= (wr_ptr == PTR_W'(WRO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= (rd_ptr == PTR_W'(WRO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            fifo_cnt <= fifo_cnt + CNT_W'(push) - CNT_W'(pop);

            // Entries drop as their response passes, then the new issue sets its own
            if (fiu_rsp.valid)
            begin
                tbl_valid[rsp_tag] <= 1'b0;
            end
            if (issue_go)
            begin
                tbl_valid[head_tag] <= 1'b1;
            end

            fiu_req   <= issue_go ? head : '0;
            up_credit <= issue_go;
            fiu_cnt   <= fiu_cnt + CRD_W'(fiu_credit) - CRD_W'(issue_go);

            // Responses pass through one register stage unchanged
            up_rsp <= fiu_rsp;
        end
    end

    // ==================================================
    // Checks
    // ==================================================

    // The memory port never returns more credits than it handed out
    a_fiu_credit_bound: assert property (@(posedge clk) disable iff (!arst_n)
        fiu_cnt <= CRD_W'(FIU_CREDITS));

    // Tags from the reorder shim are not reused before their response came back
    a_tag_unique: assert property (@(posedge clk) disable iff (!arst_n)
        issue_go |-> !tbl_valid[head_tag]);

endmodule

/* mpf_rsp_order.sv */
// ROB_DEPTH must be a power of two up to 128; the client must never send without a credit
`timescale 1ns/1ps

module mpf_rsp_order
    import mpf_pkg::*;
#(
    parameter int ROB_DEPTH = 8,
    parameter int WRO_DEPTH = 4
)
(
    input  logic     clk,
    input  logic     arst_n,
    input  mpf_req_t afu_req,
    output logic     afu_credit,
    output mpf_rsp_t afu_rsp,
    output mpf_req_t fiu_req,
    input  logic     fiu_credit,
    input  mpf_rsp_t fiu_rsp
);

    localparam int TAG_W = mpf_tag_w(ROB_DEPTH);
    localparam int CNT_W = $clog2(WRO_DEPTH + 1);

    // Pointers carry one extra bit so a full ring differs from an empty one
    logic [TAG_W:0]         alloc_ptr;
    logic [TAG_W:0]         issue_ptr;
    logic [TAG_W:0]         retire_ptr;
    logic [TAG_W:0]         occupancy;
    logic [TAG_W:0]         outstanding;
    logic [TAG_W-1:0]       retire_idx;
    logic [TAG_W-1:0]       rsp_tag;
    logic [TAG_W-1:0]       rsp_rel;

    // Slot storage, the original request and the returned read data
    mpf_req_t               slot_req  [ROB_DEPTH];
    logic [MPF_DATA_W-1:0]  slot_data [ROB_DEPTH];
    logic [ROB_DEPTH-1:0]   slot_done;

    // Credits held for the write-order shim below
    logic [CNT_W-1:0]       dn_cnt;

    logic                   ring_empty;
    logic                   issue_go;
    mpf_req_t               issue_out;
    logic                   rsp_hit;
    logic                   retire_go;
    mpf_rsp_t               retire_out;

    assign retire_idx  = retire_ptr[TAG_W-1:0];
    assign rsp_tag     = fiu_rsp.mdata[TAG_W-1:0];
    assign rsp_rel     = rsp_tag - retire_idx;
    assign occupancy   = alloc_ptr - retire_ptr;
    assign outstanding = issue_ptr - retire_ptr;
    assign ring_empty  = (issue_ptr == alloc_ptr);

    // ==================================================
    // Issue toward the write-order shim
    // ==================================================

    // With nothing waiting in the ring a new request bypasses storage,
    // so it reaches the output register in the cycle it arrives
    // Its slot index equals issue_ptr in both cases
    always_comb
    begin
        issue_out = ring_empty ? afu_req : slot_req[issue_ptr[TAG_W-1:0]];
        issue_go  = (ring_empty ? afu_req.valid : 1'b1) && (dn_cnt != '0);
        issue_out.valid = issue_go;
        issue_out.mdata = MPF_MDATA_W'(issue_ptr[TAG_W-1:0]);
    end

    // ==================================================
    // Retire toward the client
    // ==================================================

    // A response for the head slot retires straight from the input
    // Later slots park their data until the head catches up
    always_comb
    begin
        rsp_hit   = fiu_rsp.valid && (rsp_tag == retire_idx);
        retire_go = (retire_ptr != issue_ptr) && (slot_done[retire_idx] || rsp_hit);
        retire_out.valid    = retire_go;
        retire_out.is_write = slot_req[retire_idx].is_write;
        retire_out.mdata    = slot_req[retire_idx].mdata;
        retire_out.data     = slot_done[retire_idx] ? slot_data[retire_idx] : fiu_rsp.data;
        // Writes never return data to the client
        if (slot_req[retire_idx].is_write)
        begin
            retire_out.data = '0;
        end
    end

    // Slot storage needs no reset since slot_done and the pointers guard it
    always_ff @(posedge clk)
    begin
        if (afu_req.valid)
        begin
            slot_req[alloc_ptr[TAG_W-1:0]] <= afu_req;
        end
        if (fiu_rsp.valid)
        begin
            slot_data[rsp_tag] <= fiu_rsp.data;
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            alloc_ptr  <= '0;
            issue_ptr  <= '0;
            retire_ptr <= '0;
            dn_cnt     <= CNT_W'(WRO_DEPTH);
            slot_done  <= '0;
            fiu_req    <= '0;
            afu_rsp    <= '0;
            afu_credit <= 1'b0;
        end
        else
        begin
            if (afu_req.valid)
            begin
                alloc_ptr <= alloc_ptr + 1'b1;
            end

            // Registered downstream request, zero when idle
            fiu_req <= issue_go ? issue_out : '0;
            if (issue_go)
            begin
                issue_ptr <= issue_ptr + 1'b1;
            end
            dn_cnt <= dn_cnt + CNT_W'(fiu_credit) - CNT_W'(issue_go);

            // Mark arrivals first, so a bypassed head retire below clears its own mark
            if (fiu_rsp.valid)
            begin
                slot_done[rsp_tag] <= 1'b1;
            end

            // The client credit rides with the retired response
            afu_rsp    <= retire_go ? retire_out : '0;
            afu_credit <= retire_go;
            if (retire_go)
            begin
                slot_done[retire_idx] <= 1'b0;
                retire_ptr <= retire_ptr + 1'b1;
            end
        end
    end

    // ==================================================
    // Checks
    // ==================================================

    // The client credit count must keep it from sending into a full ring
    a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
        afu_req.valid |-> (occupancy != (TAG_W + 1)'(ROB_DEPTH)));

    // The memory side must echo tags of issued slots still waiting for data
    a_rsp_tag_live: assert property (@(posedge clk) disable iff (!arst_n)
        fiu_rsp.valid |-> (({1'b0, rsp_rel} < outstanding) && !slot_done[rsp_tag]));

endmodule

/* mpf_pkg.sv */
// Lines are single 64-bit words and the reorder tag must fit in the low bits of mdata
package mpf_pkg;

    // ==================================================
    // Widths shared by every hop of the shim stack
    // ==================================================

    // Line address, one address per 64-bit line
    localparam int MPF_ADDR_W  = 16;
    localparam int MPF_DATA_W  = 64;

    // Client metadata, returned untouched with the response
    localparam int MPF_MDATA_W = 8;

    // ==================================================
    // Request and response words
    // ==================================================

    // One request per cycle while valid is high, spending one credit
    typedef struct packed {
        logic                   valid;
        logic                   is_write;
        logic [MPF_ADDR_W-1:0]  addr;
        logic [MPF_DATA_W-1:0]  data;
        logic [MPF_MDATA_W-1:0] mdata;
    } mpf_req_t;

    // Responses have no back-pressure
    // Write responses leave data at zero
    typedef struct packed {
        logic                   valid;
        logic                   is_write;
        logic [MPF_DATA_W-1:0]  data;
        logic [MPF_MDATA_W-1:0] mdata;
    } mpf_rsp_t;

    // ==================================================
    // Helpers
    // ==================================================

    // Number of bits needed to index a ring of the given depth
    // A depth of one still gets a one-bit index
    function automatic int mpf_tag_w(input int depth);
        int w;
        w = 0;
        while ((1 << w) < depth)
        begin
            w++;
        end
        return (w < 1) ? 1 : w;
    endfunction

endpackage
